/* source/cpu_pkg.sv */
// cpu package: word types, opcodes, error codes and stage packets
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [2:0]  reg_idx_t;

  typedef enum logic [3:0] {
    op_add   = 4'h0,
    op_sub   = 4'h1,
    op_and   = 4'h2,
    op_xor   = 4'h3,
    op_addi  = 4'h4,
    op_load  = 4'h5,
    op_store = 4'h6,
    op_halt  = 4'h7
  } opcode_e;

  typedef enum logic [1:0] {
    no_error          = 2'd0,
    halted_on_halt    = 2'd1,
    halted_on_illegal = 2'd2
  } error_e;

  // instruction word
  //   [31:28] opcode   [27:25] rd   [24:22] rs1   [21:19] rs2
  //   [18:16] unused   [15:0]  signed immediate
  typedef struct packed {
    logic [3:0] opcode;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    word_t      imm;
  } inst_fields_t;

  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t inst;
  } f_d_packet_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    opcode_e  opcode;
    reg_idx_t rd;
    logic     wr_en;
    word_t    opa;
    word_t    opb;
    word_t    store_data;
    logic     illegal;
  } d_x_packet_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    opcode_e  opcode;
    reg_idx_t rd;
    logic     wr_en;
    word_t    result;
    word_t    store_data;
    logic     illegal;
  } x_m_packet_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    logic     wr_en;
    reg_idx_t rd;
    word_t    data;
    error_e   error;
  } commit_t;

  // split an instruction word into its fields, immediate sign extended
  function automatic inst_fields_t decode_inst(word_t inst);
    inst_fields_t f;
    f.opcode = inst[31:28];
    f.rd     = inst[27:25];
    f.rs1    = inst[24:22];
    f.rs2    = inst[21:19];
    f.imm    = {{16{inst[15]}}, inst[15:0]};
    return f;
  endfunction

  function automatic logic is_legal(logic [3:0] code);
    case (code)
      op_add, op_sub, op_and, op_xor,
      op_addi, op_load, op_store, op_halt: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage

/* source/wb_if.sv */
// wishbone classic point-to-point bus between a stage and the arbiter
interface wb_if #(
  parameter int addr_width = 12
);

  // master side
  logic                  cyc;
  logic                  stb;
  logic                  we;
  logic [addr_width-1:0] adr;
  cpu_pkg::word_t        dat_w;

  // slave side
  cpu_pkg::word_t        dat_r;
  logic                  ack;

  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack
  );

endinterface

/* source/bus_arbiter.sv */
// bus arbiter that shares the external wishbone bus between data and fetch
module bus_arbiter #(
  parameter int addr_width = 12
) (
  input  logic                  clock,
  input  logic                  rst_n,
  wb_if.slave                   fetch_bus,
  wb_if.slave                   data_bus,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic                  wb_we,
  output logic [addr_width-1:0] wb_adr,
  output cpu_pkg::word_t        wb_dat_w,
  input  cpu_pkg::word_t        wb_dat_r,
  input  logic                  wb_ack
);

  typedef enum logic [1:0] {
    own_idle,
    own_fetch,
    own_data
  } owner_e;

  owner_e owner_q;
  owner_e owner;

  // owner lets go once its cyc drops
  // an idle bus is granted in the same cycle with data first
  always_comb begin
    owner = owner_q;
    if (owner_q == own_fetch && !fetch_bus.cyc) owner = own_idle;
    if (owner_q == own_data && !data_bus.cyc) owner = own_idle;
    if (owner == own_idle) begin
      if (data_bus.cyc) owner = own_data;
      else if (fetch_bus.cyc) owner = own_fetch;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) owner_q <= own_idle;
    else        owner_q <= owner;
  end

  //////////////////////////////////////////////////////////////////////
  // request mux toward the external slave
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    case (owner)
      own_fetch: begin
        wb_cyc   = fetch_bus.cyc;
        wb_stb   = fetch_bus.stb;
        wb_we    = fetch_bus.we;
        wb_adr   = fetch_bus.adr;
        wb_dat_w = fetch_bus.dat_w;
      end
      own_data: begin
        wb_cyc   = data_bus.cyc;
        wb_stb   = data_bus.stb;
        wb_we    = data_bus.we;
        wb_adr   = data_bus.adr;
        wb_dat_w = data_bus.dat_w;
      end
      default: ;
    endcase
  end

  // read data fans out and ack goes only to whoever holds the bus
  assign fetch_bus.dat_r = wb_dat_r;
  assign data_bus.dat_r  = wb_dat_r;
  assign fetch_bus.ack   = wb_ack && (owner == own_fetch);
  assign data_bus.ack    = wb_ack && (owner == own_data);

  // every external ack lands on exactly one port
  a_single_ack : assert property (@(posedge clock) disable iff (!rst_n)
    wb_ack |-> (fetch_bus.ack != data_bus.ack));

  a_stb_in_cyc : assert property (@(posedge clock) disable iff (!rst_n)
    wb_stb |-> wb_cyc);

endmodule

/* source/fetch_stage.sv */
// fetch stage: program counter, wishbone instruction reads, one-entry buffer
module fetch_stage #(
  parameter int addr_width = 12
) (
  input  logic                 clock,
  input  logic                 rst_n,
  wb_if.master                 bus,
  input  logic                 stall,
  input  logic                 halt_seen,
  output cpu_pkg::f_d_packet_t f_packet
);

  logic [addr_width-1:0] pc_q;
  logic                  req_q;
  logic                  stop_q;
  logic                  consumed;
  logic                  can_issue;
  logic                  last_inst;

  // decode takes the buffered instruction this cycle
  assign consumed = f_packet.valid && !stall;

  // buffer is free at ack time when issued under this condition
  assign can_issue = !stop_q && !halt_seen && (!f_packet.valid || consumed);

  // halt or illegal ends the program, no reads past it
  assign last_inst = (bus.dat_r[31:28] == cpu_pkg::op_halt) ||
                     !cpu_pkg::is_legal(bus.dat_r[31:28]);

  // read only, address is the pc itself
  assign bus.cyc   = req_q;
  assign bus.stb   = req_q;
  assign bus.we    = 1'b0;
  assign bus.adr   = pc_q;
  assign bus.dat_w = '0;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      pc_q     <= '0;
      req_q    <= 1'b0;
      stop_q   <= 1'b0;
      f_packet <= '0;
    end else begin
      // request drops for a cycle after every ack
      if (req_q && bus.ack) req_q <= 1'b0;
      else if (!req_q && can_issue) req_q <= 1'b1;

      if (req_q && bus.ack) begin
        f_packet.valid <= 1'b1;
        f_packet.pc    <= cpu_pkg::word_t'(pc_q);
        f_packet.inst  <= bus.dat_r;
        pc_q           <= pc_q + 1'b1;
        if (last_inst) stop_q <= 1'b1;
      end else if (consumed) begin
        f_packet.valid <= 1'b0;
      end
    end
  end

  a_adr_stable : assert property (@(posedge clock) disable iff (!rst_n)
    bus.stb && !bus.ack |=> $stable(bus.adr));

endmodule

/* source/decode_stage.sv */
// decode stage: field decode, register file, scoreboard and hazard stall
module decode_stage (
  input  logic                 clock,
  input  logic                 rst_n,
  input  cpu_pkg::f_d_packet_t f_packet,
  input  logic                 mem_busy,
  input  cpu_pkg::commit_t     commit,
  output logic                 fetch_stall,
  output cpu_pkg::d_x_packet_t d_packet
);

  cpu_pkg::word_t        regs [8];
  logic [7:0]            pending_q;
  cpu_pkg::inst_fields_t fields;
  cpu_pkg::opcode_e      opcode;
  logic                  illegal;
  logic                  uses_rs1;
  logic                  uses_rs2;
  logic                  uses_imm;
  logic                  writes;
  logic                  wr_en;
  logic                  hazard;
  logic                  issue;
  cpu_pkg::word_t        rs1_val;
  cpu_pkg::word_t        rs2_val;

  assign fields  = cpu_pkg::decode_inst(f_packet.inst);
  assign opcode  = cpu_pkg::opcode_e'(fields.opcode);
  assign illegal = !cpu_pkg::is_legal(fields.opcode);

  // operand usage per class
  always_comb begin
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    uses_imm = 1'b0;
    writes   = 1'b0;
    if (!illegal) begin
      case (opcode)
        cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and, cpu_pkg::op_xor: begin
          uses_rs1 = 1'b1;
          uses_rs2 = 1'b1;
          writes   = 1'b1;
        end
        cpu_pkg::op_addi, cpu_pkg::op_load: begin
          uses_rs1 = 1'b1;
          uses_imm = 1'b1;
          writes   = 1'b1;
        end
        cpu_pkg::op_store: begin
          uses_rs1 = 1'b1;
          uses_rs2 = 1'b1;
          uses_imm = 1'b1;
        end
        default: ;
      endcase
    end
  end

  // r0 is never written, so it reads zero
  assign wr_en   = writes && (fields.rd != '0);
  assign rs1_val = regs[fields.rs1];
  assign rs2_val = regs[fields.rs2];

  //////////////////////////////////////////////////////////////////////
  // scoreboard interlock
  //////////////////////////////////////////////////////////////////////
  // sources pending, or rd still owed by an older writer
  assign hazard = f_packet.valid &&
                  ((uses_rs1 && pending_q[fields.rs1]) ||
                   (uses_rs2 && pending_q[fields.rs2]) ||
                   (wr_en && pending_q[fields.rd]));

  assign issue       = f_packet.valid && !hazard && !mem_busy;
  assign fetch_stall = hazard || mem_busy;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      pending_q <= '0;
      for (int i = 0; i < 8; i++) regs[i] <= '0;
    end else begin
      // writeback from the memory stage commit record
      if (commit.valid && commit.wr_en && commit.rd != '0) begin
        regs[commit.rd]      <= commit.data;
        pending_q[commit.rd] <= 1'b0;
      end
      if (issue && wr_en) pending_q[fields.rd] <= 1'b1;
    end
  end

  // output register, frozen while memory is busy, bubble on hazard
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      d_packet <= '0;
    end else if (!mem_busy) begin
      d_packet.valid      <= issue;
      d_packet.pc         <= f_packet.pc;
      d_packet.opcode     <= opcode;
      d_packet.rd         <= fields.rd;
      d_packet.wr_en      <= wr_en;
      d_packet.opa        <= rs1_val;
      d_packet.opb        <= uses_imm ? fields.imm : rs2_val;
      d_packet.store_data <= rs2_val;
      d_packet.illegal    <= illegal;
    end
  end

endmodule

/* source/execute_stage.sv */
// execute stage: alu and effective address with its output register
module execute_stage (
  input  logic                 clock,
  input  logic                 rst_n,
  input  cpu_pkg::d_x_packet_t d_packet,
  input  logic                 mem_busy,
  output cpu_pkg::x_m_packet_t x_packet
);

  cpu_pkg::word_t result;

  // addi, load and store all take the plain sum
  always_comb begin
    case (d_packet.opcode)
      cpu_pkg::op_sub: result = d_packet.opa - d_packet.opb;
      cpu_pkg::op_and: result = d_packet.opa & d_packet.opb;
      cpu_pkg::op_xor: result = d_packet.opa ^ d_packet.opb;
      default:         result = d_packet.opa + d_packet.opb;
    endcase
  end

  // holds while memory works on the previous packet
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      x_packet <= '0;
    end else if (!mem_busy) begin
      x_packet.valid      <= d_packet.valid;
      x_packet.pc         <= d_packet.pc;
      x_packet.opcode     <= d_packet.opcode;
      x_packet.rd         <= d_packet.rd;
      x_packet.wr_en      <= d_packet.wr_en;
      x_packet.result     <= result;
      x_packet.store_data <= d_packet.store_data;
      x_packet.illegal    <= d_packet.illegal;
    end
  end

endmodule

/* source/memory_stage.sv */
// memory stage: wishbone loads and stores, commit record and writeback
module memory_stage #(
  parameter int addr_width = 12
) (
  input  logic                 clock,
  input  logic                 rst_n,
  input  cpu_pkg::x_m_packet_t x_packet,
  wb_if.master                 bus,
  output logic                 mem_busy,
  output cpu_pkg::commit_t     commit
);

  typedef enum logic [1:0] {
    mem_idle,
    mem_access,
    mem_done
  } state_e;

  state_e state_q;
  logic   halted;
  logic   is_mem;
  logic   take;

  assign halted = (commit.error != cpu_pkg::no_error);
  assign is_mem = !x_packet.illegal &&
                  (x_packet.opcode == cpu_pkg::op_load ||
                   x_packet.opcode == cpu_pkg::op_store);

  // new packet handled only from idle, done skips the finished one
  assign take = (state_q == mem_idle) && x_packet.valid && !halted;

  // freeze upstream from request until the ack has been taken
  assign mem_busy = (take && is_mem) || (state_q == mem_access);

  // packet is frozen during access, so the request holds steady
  assign bus.cyc   = (state_q == mem_access);
  assign bus.stb   = (state_q == mem_access);
  assign bus.we    = (x_packet.opcode == cpu_pkg::op_store);
  assign bus.adr   = x_packet.result[addr_width-1:0];
  assign bus.dat_w = x_packet.store_data;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state_q <= mem_idle;
      commit  <= '0;
    end else begin
      commit.valid <= 1'b0;
      commit.pc    <= x_packet.pc;
      commit.rd    <= x_packet.rd;
      commit.wr_en <= 1'b0;
      case (state_q)
        mem_idle: begin
          if (take) begin
            if (x_packet.illegal) begin
              commit.valid <= 1'b1;
              commit.error <= cpu_pkg::halted_on_illegal;
            end else if (x_packet.opcode == cpu_pkg::op_halt) begin
              commit.valid <= 1'b1;
              commit.error <= cpu_pkg::halted_on_halt;
            end else if (is_mem) begin
              state_q <= mem_access;
            end else begin
              // alu result goes straight to the commit record
              commit.valid <= 1'b1;
              commit.wr_en <= x_packet.wr_en;
              commit.data  <= x_packet.result;
            end
          end
        end
        mem_access: begin
          if (bus.ack) begin
            commit.valid <= 1'b1;
            commit.wr_en <= x_packet.wr_en && !bus.we;
            commit.data  <= bus.we ? x_packet.store_data : bus.dat_r;
            state_q      <= mem_done;
          end
        end
        default: state_q <= mem_idle;
      endcase
    end
  end

  // error is sticky, so a halt is the last commit until reset
  a_no_commit_after_halt : assert property (@(posedge clock) disable iff (!rst_n)
    commit.error != cpu_pkg::no_error |=> !commit.valid);

endmodule

/* source/pipeline.sv */
// pipeline top: four stages sharing one wishbone bus, commit ports out
module pipeline #(
  parameter int addr_width = 12
) (
  input  logic                  clock,
  input  logic                  rst_n,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic                  wb_we,
  output logic [addr_width-1:0] wb_adr,
  output cpu_pkg::word_t        wb_dat_w,
  input  cpu_pkg::word_t        wb_dat_r,
  input  logic                  wb_ack,
  output logic                  commit_valid,
  output cpu_pkg::word_t        commit_pc,
  output logic                  commit_wr_en,
  output cpu_pkg::reg_idx_t     commit_wr_idx,
  output cpu_pkg::word_t        commit_wr_data,
  output cpu_pkg::error_e       error_status
);

  cpu_pkg::f_d_packet_t f_packet;
  cpu_pkg::d_x_packet_t d_packet;
  cpu_pkg::x_m_packet_t x_packet;
  cpu_pkg::commit_t     commit;
  logic                 fetch_stall;
  logic                 mem_busy;
  logic                 halt_seen;

  wb_if #(.addr_width(addr_width)) fetch_bus ();
  wb_if #(.addr_width(addr_width)) data_bus ();

  assign halt_seen = (commit.error != cpu_pkg::no_error);

  //////////////////////////////////////////////////////////////////////
  // stages
  //////////////////////////////////////////////////////////////////////
  fetch_stage #(.addr_width(addr_width)) i_fetch (
    .clock     (clock),
    .rst_n     (rst_n),
    .bus       (fetch_bus.master),
    .stall     (fetch_stall),
    .halt_seen (halt_seen),
    .f_packet  (f_packet)
  );

  decode_stage i_decode (
    .clock       (clock),
    .rst_n       (rst_n),
    .f_packet    (f_packet),
    .mem_busy    (mem_busy),
    .commit      (commit),
    .fetch_stall (fetch_stall),
    .d_packet    (d_packet)
  );

  execute_stage i_execute (
    .clock    (clock),
    .rst_n    (rst_n),
    .d_packet (d_packet),
    .mem_busy (mem_busy),
    .x_packet (x_packet)
  );

  memory_stage #(.addr_width(addr_width)) i_memory (
    .clock    (clock),
    .rst_n    (rst_n),
    .x_packet (x_packet),
    .bus      (data_bus.master),
    .mem_busy (mem_busy),
    .commit   (commit)
  );

  // external bus
  bus_arbiter #(.addr_width(addr_width)) i_arbiter (
    .clock     (clock),
    .rst_n     (rst_n),
    .fetch_bus (fetch_bus.slave),
    .data_bus  (data_bus.slave),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack)
  );

  // commit record out to the ports
  assign commit_valid   = commit.valid;
  assign commit_pc      = commit.pc;
  assign commit_wr_en   = commit.valid && commit.wr_en;
  assign commit_wr_idx  = commit.rd;
  assign commit_wr_data = commit.data;
  assign error_status   = commit.error;

endmodule

/* test/clock_gen.sv */
// clock and reset source for the testbench, 10 ns period, 3 cycle reset
module clock_gen (
  input  logic reset_req,
  output logic clock,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // low for three edges, again on every request
  always begin
    rst_n = 1'b0;
    repeat (3) @(posedge clock);
    #1 rst_n = 1'b1;
    wait (reset_req);
    @(posedge clock);
    #1;
  end

endmodule

/* test/tb_pipeline.sv */
// pipeline testbench with random programs, a wishbone memory model and a reference model
module tb_pipeline;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int addr_width  = 12;
  localparam int depth       = 1 << addr_width;
  localparam int data_base   = 1 << (addr_width - 1);
  localparam int prog1_len   = 60;
  localparam int prog2_len   = 40;
  localparam int illegal_at  = 25;
  // length x 5 stages x 4 wait cycles x 10 ns plus margin
  localparam int watchdog_ns = (prog1_len + prog2_len) * 5 * 4 * 10 + 2000;

  typedef struct {
    cpu_pkg::word_t    pc;
    logic              wr;
    cpu_pkg::reg_idx_t idx;
    cpu_pkg::word_t    data;
    cpu_pkg::error_e   err;
  } exp_commit_t;

  logic                  clock;
  logic                  rst_n;
  logic                  reset_req;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [addr_width-1:0] wb_adr;
  cpu_pkg::word_t        wb_dat_w;
  cpu_pkg::word_t        wb_dat_r;
  logic                  wb_ack;
  logic                  commit_valid;
  cpu_pkg::word_t        commit_pc;
  logic                  commit_wr_en;
  cpu_pkg::reg_idx_t     commit_wr_idx;
  cpu_pkg::word_t        commit_wr_data;
  cpu_pkg::error_e       error_status;

  // bus memory and the reference copy
  cpu_pkg::word_t mem [depth];
  cpu_pkg::word_t model_mem [depth];
  exp_commit_t    exp_q [$];
  exp_commit_t    want;

  logic [15:0]           lfsr_q;
  int                    value_errs;
  int                    bus_errs;
  int                    order_errs;
  logic                  prog_done;
  logic                  slave_busy;
  int                    wait_cnt;
  logic                  go_ack;
  cpu_pkg::word_t        slave_rd;
  logic                  hold_q;
  logic [addr_width-1:0] adr_q;
  logic                  we_q;
  cpu_pkg::word_t        dat_q;

  clock_gen i_clock_gen (
    .reset_req (reset_req),
    .clock     (clock),
    .rst_n     (rst_n)
  );

  pipeline #(.addr_width(addr_width)) i_dut (
    .clock          (clock),
    .rst_n          (rst_n),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_w       (wb_dat_w),
    .wb_dat_r       (wb_dat_r),
    .wb_ack         (wb_ack),
    .commit_valid   (commit_valid),
    .commit_pc      (commit_pc),
    .commit_wr_en   (commit_wr_en),
    .commit_wr_idx  (commit_wr_idx),
    .commit_wr_data (commit_wr_data),
    .error_status   (error_status)
  );

  //////////////////////////////////////////////////////////////////////
  // random source
  //////////////////////////////////////////////////////////////////////
  // galois lfsr with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) return (s >> 1) ^ 16'hb400;
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // program and reference model
  //////////////////////////////////////////////////////////////////////
  // pattern built from every address bit
  task automatic fill_memory();
    int a;
    for (a = 0; a < depth; a++) begin
      mem[a]       = {a[11:0], 8'hc3, ~a[11:0]};
      model_mem[a] = mem[a];
    end
  endtask

  task automatic build_program(input int len, input int bad_at);
    int          i;
    logic [2:0]  sel;
    logic [2:0]  rd;
    logic [2:0]  rs1;
    logic [2:0]  rs2;
    logic [2:0]  last_rd;
    logic [3:0]  op;
    logic [15:0] imm;
    last_rd = 3'd1;
    for (i = 0; i < len; i++) begin
      sel = take_bits(3);
      rd  = take_bits(3);
      rs1 = take_bits(3);
      rs2 = take_bits(3);
      imm = take_bits(16);
      // half the time chain onto the previous result
      if (take_bits(1)) rs1 = last_rd;
      case (sel)
        3'd0: op = cpu_pkg::op_add;
        3'd1: op = cpu_pkg::op_sub;
        3'd2: op = cpu_pkg::op_and;
        3'd3: op = cpu_pkg::op_xor;
        3'd5: op = cpu_pkg::op_load;
        3'd6: op = cpu_pkg::op_store;
        default: op = cpu_pkg::op_addi;
      endcase
      // r0 base and data in the upper half only
      if (op == cpu_pkg::op_load || op == cpu_pkg::op_store) begin
        rs1 = 3'd0;
        imm = 16'(data_base) | (imm & 16'(data_base - 1));
      end
      if (i == len - 1) op = cpu_pkg::op_halt;
      else if (i == bad_at) op = {1'b1, sel};
      mem[i]       = {op, rd, rs1, rs2, 3'b000, imm};
      model_mem[i] = mem[i];
      last_rd      = rd;
    end
  endtask

  // runs the program in order with one expected commit per instruction
  task automatic run_reference();
    cpu_pkg::word_t        regs [8];
    cpu_pkg::word_t        inst;
    cpu_pkg::word_t        a;
    cpu_pkg::word_t        b;
    cpu_pkg::word_t        imm;
    cpu_pkg::word_t        ea;
    logic [addr_width-1:0] addr;
    exp_commit_t           e;
    int                    pc;
    int                    i;
    logic                  done;
    for (i = 0; i < 8; i++) regs[i] = '0;
    pc   = 0;
    done = 1'b0;
    while (!done) begin
      inst   = model_mem[pc];
      a      = regs[inst[24:22]];
      b      = regs[inst[21:19]];
      imm    = {{16{inst[15]}}, inst[15:0]};
      ea     = a + imm;
      addr   = ea[addr_width-1:0];
      e.pc   = cpu_pkg::word_t'(pc);
      e.wr   = 1'b0;
      e.idx  = inst[27:25];
      e.data = '0;
      e.err  = cpu_pkg::no_error;
      case (inst[31:28])
        cpu_pkg::op_add: {e.wr, e.data} = {1'b1, a + b};
        cpu_pkg::op_sub: {e.wr, e.data} = {1'b1, a - b};
        cpu_pkg::op_and: {e.wr, e.data} = {1'b1, a & b};
        cpu_pkg::op_xor: {e.wr, e.data} = {1'b1, a ^ b};
        cpu_pkg::op_addi: {e.wr, e.data} = {1'b1, ea};
        cpu_pkg::op_load: {e.wr, e.data} = {1'b1, model_mem[addr]};
        cpu_pkg::op_store: model_mem[addr] = b;
        cpu_pkg::op_halt: begin
          e.err = cpu_pkg::halted_on_halt;
          done  = 1'b1;
        end
        default: begin
          e.err = cpu_pkg::halted_on_illegal;
          done  = 1'b1;
        end
      endcase
      // r0 stays zero, so no write is reported
      if (e.idx == 3'd0) e.wr = 1'b0;
      if (e.wr) regs[e.idx] = e.data;
      exp_q.push_back(e);
      pc++;
    end
  endtask

  task automatic load_program(input int len, input int bad_at);
    prog_done = 1'b0;
    exp_q.delete();
    fill_memory();
    build_program(len, bad_at);
    run_reference();
  endtask

  task automatic check_data_region();
    int a;
    for (a = data_base; a < depth; a++) begin
      assert (mem[a] == model_mem[a]) else begin
        value_errs++;
        $display("ERR %0t: memory word %0h is %h, expected %h",
                 $time, a, mem[a], model_mem[a]);
      end
    end
  endtask

  // wait for the halt commit and then watch a quiet bus for a while
  task automatic finish_program(input cpu_pkg::error_e final_err);
    wait (prog_done);
    repeat (20) @(posedge clock);
    assert (error_status == final_err) else begin
      value_errs++;
      $display("ERR %0t: error status %s, expected %s",
               $time, error_status.name(), final_err.name());
    end
    assert (exp_q.size() == 0) else begin
      order_errs++;
      $display("%0d expected commits never arrived", exp_q.size());
    end
    check_data_region();
  endtask

  //////////////////////////////////////////////////////////////////////
  // wishbone slave with 0 to 3 wait cycles
  //////////////////////////////////////////////////////////////////////
  always @(posedge clock) begin
    go_ack = 1'b0;
    if (!rst_n) begin
      slave_busy = 1'b0;
    end else if (wb_ack) begin
      // master takes the ack at this edge
      slave_busy = 1'b0;
    end else begin
      if (!slave_busy && wb_cyc && wb_stb) begin
        slave_busy = 1'b1;
        wait_cnt   = int'(take_bits(2));
      end
      if (slave_busy) begin
        if (wait_cnt == 0) go_ack = 1'b1;
        else wait_cnt--;
      end
    end
    if (go_ack) begin
      if (wb_we) mem[wb_adr] = wb_dat_w;
      slave_rd = mem[wb_adr];
    end
    #1;
    wb_ack = go_ack;
    if (go_ack) wb_dat_r = slave_rd;
  end

  // request must hold still until the ack
  always @(posedge clock) begin
    if (rst_n && hold_q) begin
      assert (wb_stb && wb_adr == adr_q && wb_we == we_q && wb_dat_w == dat_q) else begin
        bus_errs++;
        $display("ERR %0t: request changed before ack, adr %0h was %0h",
                 $time, wb_adr, adr_q);
      end
    end
    hold_q = rst_n && wb_stb && !wb_ack;
    adr_q  = wb_adr;
    we_q   = wb_we;
    dat_q  = wb_dat_w;
  end

  //////////////////////////////////////////////////////////////////////
  // commit checker
  //////////////////////////////////////////////////////////////////////
  always @(posedge clock) begin
    if (rst_n) begin
      if (prog_done) begin
        assert (!wb_cyc) else begin
          bus_errs++;
          $display("ERR %0t: bus cycle at adr %0h after the machine halted", $time, wb_adr);
        end
      end
      if (commit_valid) begin
        assert (exp_q.size() != 0) else begin
          order_errs++;
          $display("commit from pc %0d arrived after the program had ended", commit_pc);
        end
        if (exp_q.size() != 0) begin
          want = exp_q.pop_front();
          assert (commit_pc == want.pc) else begin
            value_errs++;
            $display("ERR %0t: commit pc %0d, expected %0d", $time, commit_pc, want.pc);
          end
          assert (commit_wr_en == want.wr) else begin
            value_errs++;
            $display("ERR %0t: pc %0d write flag %b, expected %b",
                     $time, want.pc, commit_wr_en, want.wr);
          end
          if (want.wr) begin
            assert (commit_wr_idx == want.idx && commit_wr_data == want.data) else begin
              value_errs++;
              $display("ERR %0t: pc %0d wrote r%0d=%h, expected r%0d=%h", $time, want.pc,
                       commit_wr_idx, commit_wr_data, want.idx, want.data);
            end
          end
          assert (error_status == want.err) else begin
            value_errs++;
            $display("ERR %0t: pc %0d error status %s, expected %s",
                     $time, want.pc, error_status.name(), want.err.name());
          end
        end
        // the machine itself reports when it stops
        if (error_status != cpu_pkg::no_error) prog_done = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    reset_req  = 1'b0;
    wb_ack     = 1'b0;
    wb_dat_r   = '0;
    value_errs = 0;
    bus_errs   = 0;
    order_errs = 0;
    hold_q     = 1'b0;
    slave_busy = 1'b0;
    lfsr_q     = 16'd86;

    // first run ends on halt
    load_program(prog1_len, -1);
    wait (rst_n);
    finish_program(cpu_pkg::halted_on_halt);

    // second reset, program with an illegal opcode
    @(posedge clock);
    #1 reset_req = 1'b1;
    wait (!rst_n);
    reset_req = 1'b0;
    load_program(prog2_len, illegal_at);
    wait (rst_n);
    finish_program(cpu_pkg::halted_on_illegal);

    $display("errors: value %0d, bus %0d, order %0d", value_errs, bus_errs, order_errs);
    if (value_errs + bus_errs + order_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(watchdog_ns);
    $display("timeout: the programs did not finish within %0d ns", watchdog_ns);
    $display("Test failed");
    $finish;
  end

endmodule

/* flist.f */
source/cpu_pkg.sv
source/wb_if.sv
source/bus_arbiter.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/pipeline.sv
test/clock_gen.sv
test/tb_pipeline.sv
